// File: include/dispatch_params.svh
`ifndef DISPATCH_PARAMS_SVH
`define DISPATCH_PARAMS_SVH

// Datapath widths
`define DATA_W 32
`define GR_COUNT 32
`define REG_ADDR_W 5
`define CMD_W 5
`define CC_W 4

// System register numbers
`define SYSREG_CPUIDR 5'd0
`define SYSREG_COREIDR 5'd1
`define SYSREG_TIDR 5'd2
`define SYSREG_PCR 5'd4
`define SYSREG_SPR 5'd5
`define SYSREG_PSR 5'd6
`define SYSREG_PTIDR 5'd7
`define SYSREG_PPSR 5'd8
`define SYSREG_PPCR 5'd9

// CPUIDR is {PROCESSOR_ID, PROCESSOR_REVISION}
`define PROCESSOR_ID 16'h0001
`define PROCESSOR_REVISION 16'h0002

// Instruction size, PCR reads back one step behind
`define PC_STEP 32'd4

`endif

// File: logic/dispatch.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module dispatch #(
	parameter int unsigned CORE_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic free_pipeline_stop,
	input logic free_refresh,
	input logic free_set_irq_mode,
	input logic free_clr_irq_mode,
	input logic free_ppcr_set,
	input dispatch_pkg::word_t free_ppcr,
	output dispatch_pkg::word_t sysreg_pcr,
	output dispatch_pkg::word_t sysreg_ppsr,
	output dispatch_pkg::word_t sysreg_ppcr,
	input logic prev_valid,
	input logic prev_destination_sysreg,
	input dispatch_pkg::reg_addr_t prev_destination,
	input logic prev_writeback,
	input dispatch_pkg::cmd_t prev_cmd,
	input dispatch_pkg::cc_t prev_cc,
	input dispatch_pkg::reg_addr_t prev_source0,
	input logic prev_source0_sysreg,
	input dispatch_pkg::word_t prev_source1,
	input logic prev_source1_sysreg,
	input logic prev_source1_imm,
	input dispatch_pkg::word_t prev_pc,
	output logic prev_lock,
	output logic next_valid,
	output dispatch_pkg::word_t next_sysreg_psr,
	output dispatch_pkg::word_t next_sysreg_tidr,
	output logic next_destination_sysreg,
	output dispatch_pkg::reg_addr_t next_destination,
	output logic next_writeback,
	output dispatch_pkg::cmd_t next_cmd,
	output dispatch_pkg::cc_t next_cc,
	output dispatch_pkg::word_t next_spr,
	output dispatch_pkg::word_t next_source0,
	output dispatch_pkg::word_t next_source1,
	output dispatch_pkg::reg_addr_t next_source0_ptr,
	output dispatch_pkg::reg_addr_t next_source1_ptr,
	output logic next_source0_sysreg,
	output logic next_source1_sysreg,
	output logic next_source1_imm,
	output dispatch_pkg::word_t next_pc,
	input logic next_lock,
	input logic wb_valid,
	input dispatch_pkg::word_t wb_data,
	input dispatch_pkg::reg_addr_t wb_destination,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input dispatch_pkg::word_t wb_spr,
	input dispatch_pkg::word_t wb_pc,
	input logic wb_branch,
	input dispatch_pkg::word_t wb_branch_pc
);

	dispatch_pkg::reg_addr_t source1_ptr;
	dispatch_pkg::word_t gr_data0;
	dispatch_pkg::word_t gr_data1;
	dispatch_pkg::word_t sr_data0;
	dispatch_pkg::word_t sr_data1;
	dispatch_pkg::word_t source0_value;
	dispatch_pkg::word_t source1_value;
	logic sr_hit0;
	logic sr_hit1;
	logic gr_write_enable;

	// Source 1 field doubles as immediate and pointer
	assign source1_ptr = prev_source1[`REG_ADDR_W-1:0];
	assign gr_write_enable = wb_valid && !free_pipeline_stop && !wb_destination_sysreg &&
		wb_writeback;
	assign prev_lock = next_lock;

	general_register_file i_general_register_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.write_enable(gr_write_enable), .write_addr(wb_destination), .write_data(wb_data),
		.read_addr0(prev_source0), .read_addr1(source1_ptr),
		.read_data0(gr_data0), .read_data1(gr_data1)
	);

	system_register_file #(.CORE_ID(CORE_ID)) i_system_register_file (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.wb_valid(wb_valid), .wb_destination_sysreg(wb_destination_sysreg),
		.wb_writeback(wb_writeback), .wb_spr_writeback(wb_spr_writeback),
		.wb_branch(wb_branch), .free_pipeline_stop(free_pipeline_stop),
		.free_set_irq_mode(free_set_irq_mode), .free_clr_irq_mode(free_clr_irq_mode),
		.free_ppcr_set(free_ppcr_set), .wb_destination(wb_destination),
		.wb_data(wb_data), .wb_spr(wb_spr), .wb_pc(wb_pc), .wb_branch_pc(wb_branch_pc),
		.free_ppcr(free_ppcr), .prev_pc(prev_pc),
		.read_addr0(prev_source0), .read_addr1(source1_ptr),
		.read_active0(prev_source0_sysreg), .read_active1(prev_source1_sysreg),
		.read_hit0(sr_hit0), .read_hit1(sr_hit1),
		.read_data0(sr_data0), .read_data1(sr_data1),
		.sysreg_pcr(sysreg_pcr), .sysreg_psr(next_sysreg_psr), .sysreg_ppsr(sysreg_ppsr),
		.sysreg_ppcr(sysreg_ppcr), .sysreg_spr(next_spr), .sysreg_tidr(next_sysreg_tidr)
	);

	operand_bypass i_operand_bypass (
		.source0_ptr(prev_source0), .source0_sysreg(prev_source0_sysreg),
		.source1_ptr(source1_ptr), .source1_sysreg(prev_source1_sysreg),
		.source1_imm(prev_source1_imm), .source1_imm_value(prev_source1),
		.wb_valid(wb_valid), .wb_destination_sysreg(wb_destination_sysreg),
		.wb_writeback(wb_writeback), .wb_spr_writeback(wb_spr_writeback),
		.wb_destination(wb_destination), .wb_data(wb_data), .wb_spr(wb_spr), .wb_pc(wb_pc),
		.gr_data0(gr_data0), .gr_data1(gr_data1),
		.sr_hit0(sr_hit0), .sr_hit1(sr_hit1), .sr_data0(sr_data0), .sr_data1(sr_data1),
		.source0_value(source0_value), .source1_value(source1_value)
	);

	dispatch_latch i_dispatch_latch (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.free_refresh(free_refresh), .next_lock(next_lock),
		.prev_valid(prev_valid), .prev_destination_sysreg(prev_destination_sysreg),
		.prev_writeback(prev_writeback), .prev_source0_sysreg(prev_source0_sysreg),
		.prev_source1_sysreg(prev_source1_sysreg), .prev_source1_imm(prev_source1_imm),
		.prev_destination(prev_destination), .prev_source0_ptr(prev_source0),
		.prev_source1_ptr(source1_ptr), .prev_cmd(prev_cmd), .prev_cc(prev_cc),
		.source0_value(source0_value), .source1_value(source1_value), .prev_pc(prev_pc),
		.next_valid(next_valid), .next_destination_sysreg(next_destination_sysreg),
		.next_writeback(next_writeback), .next_source0_sysreg(next_source0_sysreg),
		.next_source1_sysreg(next_source1_sysreg), .next_source1_imm(next_source1_imm),
		.next_destination(next_destination), .next_source0_ptr(next_source0_ptr),
		.next_source1_ptr(next_source1_ptr), .next_cmd(next_cmd), .next_cc(next_cc),
		.next_source0(next_source0), .next_source1(next_source1), .next_pc(next_pc)
	);

endmodule

// File: logic/dispatch_latch.sv
`timescale 1ns/100ps

module dispatch_latch (
	input logic iCLOCK,
	input logic inRESET,
	input logic free_refresh,
	input logic next_lock,
	input logic prev_valid,
	input logic prev_destination_sysreg,
	input logic prev_writeback,
	input logic prev_source0_sysreg,
	input logic prev_source1_sysreg,
	input logic prev_source1_imm,
	input dispatch_pkg::reg_addr_t prev_destination,
	input dispatch_pkg::reg_addr_t prev_source0_ptr,
	input dispatch_pkg::reg_addr_t prev_source1_ptr,
	input dispatch_pkg::cmd_t prev_cmd,
	input dispatch_pkg::cc_t prev_cc,
	input dispatch_pkg::word_t source0_value,
	input dispatch_pkg::word_t source1_value,
	input dispatch_pkg::word_t prev_pc,
	output logic next_valid,
	output logic next_destination_sysreg,
	output logic next_writeback,
	output logic next_source0_sysreg,
	output logic next_source1_sysreg,
	output logic next_source1_imm,
	output dispatch_pkg::reg_addr_t next_destination,
	output dispatch_pkg::reg_addr_t next_source0_ptr,
	output dispatch_pkg::reg_addr_t next_source1_ptr,
	output dispatch_pkg::cmd_t next_cmd,
	output dispatch_pkg::cc_t next_cc,
	output dispatch_pkg::word_t next_source0,
	output dispatch_pkg::word_t next_source1,
	output dispatch_pkg::word_t next_pc
);

	logic valid_q;

	// Control flags, refresh takes priority over a capture
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_source0_sysreg <= 1'b0;
			next_source1_sysreg <= 1'b0;
			next_source1_imm <= 1'b0;
		end else if (free_refresh) begin
			valid_q <= 1'b0;
			next_destination_sysreg <= 1'b0;
			next_writeback <= 1'b0;
			next_source0_sysreg <= 1'b0;
			next_source1_sysreg <= 1'b0;
			next_source1_imm <= 1'b0;
		end else if (!next_lock) begin
			valid_q <= prev_valid;
			next_destination_sysreg <= prev_destination_sysreg;
			next_writeback <= prev_writeback;
			next_source0_sysreg <= prev_source0_sysreg;
			next_source1_sysreg <= prev_source1_sysreg;
			next_source1_imm <= prev_source1_imm;
		end
	end

	// Payload follows the same hold rule
	always_ff @(posedge iCLOCK) begin
		if (!next_lock) begin
			next_destination <= prev_destination;
			next_source0_ptr <= prev_source0_ptr;
			next_source1_ptr <= prev_source1_ptr;
			next_cmd <= prev_cmd;
			next_cc <= prev_cc;
			next_source0 <= source0_value;
			next_source1 <= source1_value;
			next_pc <= prev_pc;
		end
	end

	// Nothing is handed over while execute holds the lock
	assign next_valid = valid_q && !next_lock;

endmodule

// File: logic/dispatch_pkg.sv
`include "dispatch_params.svh"

package dispatch_pkg;

	// Data word
	typedef logic [`DATA_W-1:0] word_t;

	// General or system register number
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// Execute command
	typedef logic [`CMD_W-1:0] cmd_t;

	// Condition code
	typedef logic [`CC_W-1:0] cc_t;

endpackage

// File: logic/general_register_file.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module general_register_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic write_enable,
	input dispatch_pkg::reg_addr_t write_addr,
	input dispatch_pkg::word_t write_data,
	input dispatch_pkg::reg_addr_t read_addr0,
	input dispatch_pkg::reg_addr_t read_addr1,
	output dispatch_pkg::word_t read_data0,
	output dispatch_pkg::word_t read_data1
);

	dispatch_pkg::word_t regs [`GR_COUNT];

	// Register 0 is an ordinary register here
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `GR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable) begin
			regs[write_addr] <= write_data;
		end
	end

	// Two combinational read ports
	assign read_data0 = regs[read_addr0];
	assign read_data1 = regs[read_addr1];

endmodule

// File: logic/operand_bypass.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module operand_bypass (
	input dispatch_pkg::reg_addr_t source0_ptr,
	input logic source0_sysreg,
	input dispatch_pkg::reg_addr_t source1_ptr,
	input logic source1_sysreg,
	input logic source1_imm,
	input dispatch_pkg::word_t source1_imm_value,
	input logic wb_valid,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input dispatch_pkg::reg_addr_t wb_destination,
	input dispatch_pkg::word_t wb_data,
	input dispatch_pkg::word_t wb_spr,
	input dispatch_pkg::word_t wb_pc,
	input dispatch_pkg::word_t gr_data0,
	input dispatch_pkg::word_t gr_data1,
	input logic sr_hit0,
	input logic sr_hit1,
	input dispatch_pkg::word_t sr_data0,
	input dispatch_pkg::word_t sr_data1,
	output dispatch_pkg::word_t source0_value,
	output dispatch_pkg::word_t source1_value
);

	logic fwd_hit0;
	logic fwd_hit1;
	dispatch_pkg::word_t fwd_data0;
	dispatch_pkg::word_t fwd_data1;

	// Writeback value seen by a source in the same cycle, with hit flag on top
	function automatic logic [`DATA_W:0] forward(
		input dispatch_pkg::reg_addr_t ptr,
		input logic sysreg
	);
		logic [`DATA_W:0] result;
		result = '0;
		if (wb_valid && sysreg && wb_destination_sysreg) begin
			if (ptr == `SYSREG_PCR) begin
				result = {1'b1, wb_pc};
			end else if (ptr == `SYSREG_SPR && wb_spr_writeback) begin
				result = {1'b1, wb_spr};
			end else if (ptr == wb_destination && wb_writeback) begin
				result = {1'b1, wb_data};
			end
		end else if (wb_valid && !sysreg && !wb_destination_sysreg && wb_writeback) begin
			if (ptr == wb_destination) begin
				result = {1'b1, wb_data};
			end
		end
		return result;
	endfunction

	// Forward, then system read on a hit, else general register
	function automatic dispatch_pkg::word_t pick(
		input logic fwd_hit,
		input dispatch_pkg::word_t fwd_data,
		input logic sysreg,
		input logic sr_hit,
		input dispatch_pkg::word_t sr_data,
		input dispatch_pkg::word_t gr_data
	);
		if (fwd_hit) begin
			return fwd_data;
		end else if (sysreg && sr_hit) begin
			return sr_data;
		end
		return gr_data;
	endfunction

	always_comb begin
		{fwd_hit0, fwd_data0} = forward(source0_ptr, source0_sysreg);
		{fwd_hit1, fwd_data1} = forward(source1_ptr, source1_sysreg);
		source0_value = pick(fwd_hit0, fwd_data0, source0_sysreg, sr_hit0, sr_data0, gr_data0);
		if (source1_imm) begin
			source1_value = source1_imm_value;
		end else begin
			source1_value = pick(fwd_hit1, fwd_data1, source1_sysreg, sr_hit1, sr_data1,
				gr_data1);
		end
	end

endmodule

// File: logic/system_register_file.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module system_register_file #(
	parameter int unsigned CORE_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic wb_valid,
	input logic wb_destination_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input logic wb_branch,
	input logic free_pipeline_stop,
	input logic free_set_irq_mode,
	input logic free_clr_irq_mode,
	input logic free_ppcr_set,
	input dispatch_pkg::reg_addr_t wb_destination,
	input dispatch_pkg::word_t wb_data,
	input dispatch_pkg::word_t wb_spr,
	input dispatch_pkg::word_t wb_pc,
	input dispatch_pkg::word_t wb_branch_pc,
	input dispatch_pkg::word_t free_ppcr,
	input dispatch_pkg::word_t prev_pc,
	input dispatch_pkg::reg_addr_t read_addr0,
	input dispatch_pkg::reg_addr_t read_addr1,
	input logic read_active0,
	input logic read_active1,
	output logic read_hit0,
	output logic read_hit1,
	output dispatch_pkg::word_t read_data0,
	output dispatch_pkg::word_t read_data1,
	output dispatch_pkg::word_t sysreg_pcr,
	output dispatch_pkg::word_t sysreg_psr,
	output dispatch_pkg::word_t sysreg_ppsr,
	output dispatch_pkg::word_t sysreg_ppcr,
	output dispatch_pkg::word_t sysreg_spr,
	output dispatch_pkg::word_t sysreg_tidr
);

	dispatch_pkg::word_t cpuidr;
	dispatch_pkg::word_t coreidr;
	dispatch_pkg::word_t tidr;
	dispatch_pkg::word_t ptidr;
	dispatch_pkg::word_t pcr;
	dispatch_pkg::word_t spr;
	dispatch_pkg::word_t psr;
	dispatch_pkg::word_t ppsr;
	dispatch_pkg::word_t ppcr;
	dispatch_pkg::word_t pcr_read;
	logic wb_ok;
	logic sys_wr;

	assign wb_ok = wb_valid && !free_pipeline_stop;
	assign sys_wr = wb_ok && wb_destination_sysreg && wb_writeback;
	assign pcr_read = prev_pc - `PC_STEP;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			cpuidr <= '0;
			coreidr <= '0;
			tidr <= '0;
			ptidr <= '0;
			pcr <= '0;
			spr <= '0;
			psr <= '0;
			ppsr <= '0;
			ppcr <= '0;
		end else begin
			// ID registers load their constants every cycle
			cpuidr <= {`PROCESSOR_ID, `PROCESSOR_REVISION};
			coreidr <= dispatch_pkg::word_t'(CORE_ID);
			if (sys_wr && wb_destination == `SYSREG_TIDR) begin
				tidr <= wb_data;
			end
			// Interrupt entry saves the task ID
			if (free_set_irq_mode) begin
				ptidr <= tidr;
			end else if (sys_wr && wb_destination == `SYSREG_PTIDR) begin
				ptidr <= wb_data;
			end
			if (wb_ok) begin
				pcr <= wb_branch ? wb_branch_pc : wb_pc;
			end
			// SPR side channel wins over a normal write
			if (wb_ok && wb_spr_writeback) begin
				spr <= wb_spr;
			end else if (sys_wr && wb_destination == `SYSREG_SPR) begin
				spr <= wb_data;
			end
			// Clear bits 6, 5 and 2 on interrupt entry
			if (free_set_irq_mode) begin
				psr <= {psr[31:7], 2'b00, psr[4:3], 1'b0, psr[1:0]};
			end else if (free_clr_irq_mode) begin
				psr <= ppsr;
			end else if (sys_wr && wb_destination == `SYSREG_PSR) begin
				psr <= wb_data;
			end
			if (free_set_irq_mode) begin
				ppsr <= psr;
			end else if (sys_wr && wb_destination == `SYSREG_PPSR) begin
				ppsr <= wb_data;
			end
			if (free_ppcr_set) begin
				ppcr <= free_ppcr;
			end else if (sys_wr && wb_destination == `SYSREG_PPCR) begin
				ppcr <= wb_data;
			end
		end
	end

	function automatic logic [`DATA_W:0] read_port(
		input logic active,
		input dispatch_pkg::reg_addr_t addr
	);
		logic [`DATA_W:0] result;
		result = '0;
		if (active) begin
			case (addr)
				`SYSREG_CPUIDR: result = {1'b1, cpuidr};
				`SYSREG_COREIDR: result = {1'b1, coreidr};
				`SYSREG_TIDR: result = {1'b1, tidr};
				`SYSREG_PCR: result = {1'b1, pcr_read};
				`SYSREG_SPR: result = {1'b1, spr};
				`SYSREG_PSR: result = {1'b1, psr};
				`SYSREG_PTIDR: result = {1'b1, ptidr};
				`SYSREG_PPSR: result = {1'b1, ppsr};
				`SYSREG_PPCR: result = {1'b1, ppcr};
				default: result = '0;
			endcase
		end
		return result;
	endfunction

	always_comb begin
		{read_hit0, read_data0} = read_port(read_active0, read_addr0);
		{read_hit1, read_data1} = read_port(read_active1, read_addr1);
	end

	assign sysreg_pcr = pcr;
	assign sysreg_psr = psr;
	assign sysreg_ppsr = ppsr;
	assign sysreg_ppcr = ppcr;
	assign sysreg_spr = spr;
	assign sysreg_tidr = tidr;

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -f sim.f --top-module dispatch_tb -o dispatch_sim

output=$(./obj_dir/dispatch_sim +verilator+error+limit+1000 || true)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
	exit 0
else
	echo "simulation did not report a pass"
	exit 1
fi

// File: sim.f
+incdir+include
logic/dispatch_pkg.sv
logic/general_register_file.sv
logic/system_register_file.sv
logic/operand_bypass.sv
logic/dispatch_latch.sv
logic/dispatch.sv
verification/dispatch_asserts.sv
verification/dispatch_checker.sv
verification/dispatch_tb.sv

// File: verification/dispatch_asserts.sv
`timescale 1ns/100ps

module dispatch_asserts (
	input logic iCLOCK,
	input logic inRESET,
	input logic free_refresh,
	input logic prev_lock,
	input logic next_lock,
	input logic next_valid
);

	int failures = 0;

	// Lock from execute goes straight back upstream
	lock_passed_back: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		prev_lock == next_lock)
	else begin
		$error("prev_lock differs from next_lock");
		failures++;
	end

	lock_hides_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		next_lock |-> !next_valid)
	else begin
		$error("next_valid high while next_lock is high");
		failures++;
	end

	refresh_clears_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		free_refresh |=> !next_valid)
	else begin
		$error("next_valid high in the cycle after free_refresh");
		failures++;
	end

endmodule

// File: verification/dispatch_checker.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module dispatch_checker #(
	parameter int unsigned CORE_ID = 0
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic free_pipeline_stop, free_refresh, free_set_irq_mode, free_clr_irq_mode,
	input logic free_ppcr_set,
	input dispatch_pkg::word_t free_ppcr,
	input logic prev_valid, prev_source0_sysreg, prev_source1_sysreg, prev_source1_imm,
	input logic prev_destination_sysreg, prev_writeback,
	input dispatch_pkg::reg_addr_t prev_destination,
	input dispatch_pkg::cmd_t prev_cmd,
	input dispatch_pkg::cc_t prev_cc,
	input dispatch_pkg::reg_addr_t prev_source0,
	input dispatch_pkg::word_t prev_source1, prev_pc,
	input logic next_lock,
	input logic wb_valid, wb_destination_sysreg, wb_writeback, wb_spr_writeback, wb_branch,
	input dispatch_pkg::reg_addr_t wb_destination,
	input dispatch_pkg::word_t wb_data, wb_spr, wb_pc, wb_branch_pc,
	input logic next_valid,
	input dispatch_pkg::word_t next_source0, next_source1,
	input logic next_destination_sysreg, next_writeback, next_source0_sysreg,
	input logic next_source1_sysreg, next_source1_imm,
	input dispatch_pkg::reg_addr_t next_destination, next_source0_ptr, next_source1_ptr,
	input dispatch_pkg::cmd_t next_cmd,
	input dispatch_pkg::cc_t next_cc,
	input dispatch_pkg::word_t next_pc,
	input dispatch_pkg::word_t next_sysreg_psr, next_sysreg_tidr, next_spr,
	input dispatch_pkg::word_t sysreg_pcr, sysreg_ppsr, sysreg_ppcr,
	output int error_count,
	output int check_count
);

	dispatch_pkg::word_t gr [`GR_COUNT];
	// System registers indexed by their number
	dispatch_pkg::word_t sr [`GR_COUNT];
	logic exp_valid;
	dispatch_pkg::word_t exp_source0;
	dispatch_pkg::word_t exp_source1;
	// Destination sysreg, writeback, source0 sysreg, source1 sysreg, source1 imm
	logic [4:0] exp_flags;
	dispatch_pkg::reg_addr_t exp_destination;
	dispatch_pkg::reg_addr_t exp_source0_ptr;
	dispatch_pkg::reg_addr_t exp_source1_ptr;
	dispatch_pkg::cmd_t exp_cmd;
	dispatch_pkg::cc_t exp_cc;
	dispatch_pkg::word_t exp_pc;

	function automatic logic sr_known(input dispatch_pkg::reg_addr_t num);
		return num inside {`SYSREG_CPUIDR, `SYSREG_COREIDR, `SYSREG_TIDR, `SYSREG_PCR,
			`SYSREG_SPR, `SYSREG_PSR, `SYSREG_PTIDR, `SYSREG_PPSR, `SYSREG_PPCR};
	endfunction

	function automatic dispatch_pkg::word_t expected_operand(
		input dispatch_pkg::reg_addr_t ptr,
		input logic sysreg
	);
		logic wb_sys;
		wb_sys = wb_valid && wb_destination_sysreg;
		if (sysreg) begin
			if (wb_sys && ptr == `SYSREG_PCR) begin
				return wb_pc;
			end
			if (wb_sys && wb_spr_writeback && ptr == `SYSREG_SPR) begin
				return wb_spr;
			end
			if (wb_sys && wb_writeback && ptr == wb_destination) begin
				return wb_data;
			end
			if (ptr == `SYSREG_PCR) begin
				return prev_pc - `PC_STEP;
			end
			if (sr_known(ptr)) begin
				return sr[ptr];
			end
		end else if (wb_valid && wb_writeback && !wb_destination_sysreg &&
			ptr == wb_destination) begin
			return wb_data;
		end
		return gr[ptr];
	endfunction

	// Valid, source 0 and source 1 for the transfer offered this cycle
	function automatic logic [64:0] expected_transfer();
		dispatch_pkg::word_t src1;
		if (prev_source1_imm) begin
			src1 = prev_source1;
		end else begin
			src1 = expected_operand(prev_source1[`REG_ADDR_W-1:0], prev_source1_sysreg);
		end
		return {prev_valid, expected_operand(prev_source0, prev_source0_sysreg), src1};
	endfunction

	always @(posedge iCLOCK) begin : model_update
		logic [64:0] expected;
		logic wb_ok;
		dispatch_pkg::word_t old_psr;
		dispatch_pkg::word_t old_ppsr;
		dispatch_pkg::word_t old_tidr;
		if (!inRESET) begin
			for (int i = 0; i < `GR_COUNT; i++) begin
				gr[i] = '0;
				sr[i] = '0;
			end
			exp_valid = 1'b0;
			exp_flags = '0;
		end else begin
			expected = expected_transfer();
			if (free_refresh) begin
				exp_valid = 1'b0;
				exp_flags = '0;
			end else if (!next_lock) begin
				exp_valid = expected[64];
				exp_flags = {prev_destination_sysreg, prev_writeback, prev_source0_sysreg,
					prev_source1_sysreg, prev_source1_imm};
			end
			if (!next_lock) begin
				exp_source0 = expected[63:32];
				exp_source1 = expected[31:0];
				exp_destination = prev_destination;
				exp_source0_ptr = prev_source0;
				exp_source1_ptr = prev_source1[`REG_ADDR_W-1:0];
				exp_cmd = prev_cmd;
				exp_cc = prev_cc;
				exp_pc = prev_pc;
			end
			wb_ok = wb_valid && !free_pipeline_stop;
			old_psr = sr[`SYSREG_PSR];
			old_ppsr = sr[`SYSREG_PPSR];
			old_tidr = sr[`SYSREG_TIDR];
			if (wb_ok && wb_writeback && !wb_destination_sysreg) begin
				gr[wb_destination] = wb_data;
			end
			if (wb_ok && wb_writeback && wb_destination_sysreg) begin
				sr[wb_destination] = wb_data;
			end
			if (wb_ok && wb_spr_writeback) begin
				sr[`SYSREG_SPR] = wb_spr;
			end
			// PCR follows the retired instruction
			if (wb_ok) begin
				sr[`SYSREG_PCR] = wb_branch ? wb_branch_pc : wb_pc;
			end
			if (free_set_irq_mode) begin
				sr[`SYSREG_PSR] = old_psr & ~32'h0000_0064;
				sr[`SYSREG_PPSR] = old_psr;
				sr[`SYSREG_PTIDR] = old_tidr;
			end else if (free_clr_irq_mode) begin
				sr[`SYSREG_PSR] = old_ppsr;
			end
			if (free_ppcr_set) begin
				sr[`SYSREG_PPCR] = free_ppcr;
			end
			sr[`SYSREG_CPUIDR] = {`PROCESSOR_ID, `PROCESSOR_REVISION};
			sr[`SYSREG_COREIDR] = dispatch_pkg::word_t'(CORE_ID);
		end
	end

	task automatic check_value(input string name, input dispatch_pkg::word_t expected,
		input dispatch_pkg::word_t actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	// Outputs settle after the rising edge, compare on the falling one
	always @(negedge iCLOCK) begin
		if (!inRESET) begin
			error_count = 0;
			check_count = 0;
		end else begin
			check_value("next_valid", {31'd0, exp_valid && !next_lock}, {31'd0, next_valid});
			check_value("next_destination_sysreg", 32'(exp_flags[4]),
				32'(next_destination_sysreg));
			check_value("next_writeback", 32'(exp_flags[3]), 32'(next_writeback));
			check_value("next_source0_sysreg", 32'(exp_flags[2]), 32'(next_source0_sysreg));
			check_value("next_source1_sysreg", 32'(exp_flags[1]), 32'(next_source1_sysreg));
			check_value("next_source1_imm", 32'(exp_flags[0]), 32'(next_source1_imm));
			if (exp_valid) begin
				check_value("next_source0", exp_source0, next_source0);
				check_value("next_source1", exp_source1, next_source1);
				check_value("next_destination", 32'(exp_destination), 32'(next_destination));
				check_value("next_source0_ptr", 32'(exp_source0_ptr), 32'(next_source0_ptr));
				check_value("next_source1_ptr", 32'(exp_source1_ptr), 32'(next_source1_ptr));
				check_value("next_cmd", 32'(exp_cmd), 32'(next_cmd));
				check_value("next_cc", 32'(exp_cc), 32'(next_cc));
				check_value("next_pc", exp_pc, next_pc);
			end
			check_value("next_sysreg_psr", sr[`SYSREG_PSR], next_sysreg_psr);
			check_value("next_sysreg_tidr", sr[`SYSREG_TIDR], next_sysreg_tidr);
			check_value("next_spr", sr[`SYSREG_SPR], next_spr);
			check_value("sysreg_pcr", sr[`SYSREG_PCR], sysreg_pcr);
			check_value("sysreg_ppsr", sr[`SYSREG_PPSR], sysreg_ppsr);
			check_value("sysreg_ppcr", sr[`SYSREG_PPCR], sysreg_ppcr);
		end
	end

endmodule

// File: verification/dispatch_tb.sv
`timescale 1ns/100ps
`include "dispatch_params.svh"

module dispatch_tb;

	localparam int unsigned CORE_ID = 3;
	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_NS = (NUM_TESTS * 200 + RESET_CYCLES) * 10;

	logic iCLOCK;
	logic inRESET;
	logic free_pipeline_stop, free_refresh, free_set_irq_mode, free_clr_irq_mode;
	logic free_ppcr_set;
	dispatch_pkg::word_t free_ppcr, sysreg_pcr, sysreg_ppsr, sysreg_ppcr;
	logic prev_valid, prev_destination_sysreg, prev_writeback, prev_source0_sysreg;
	logic prev_source1_sysreg, prev_source1_imm, prev_lock, next_lock;
	dispatch_pkg::reg_addr_t prev_destination, prev_source0;
	dispatch_pkg::cmd_t prev_cmd, next_cmd;
	dispatch_pkg::cc_t prev_cc, next_cc;
	dispatch_pkg::word_t prev_source1, prev_pc;
	logic next_valid, next_destination_sysreg, next_writeback;
	logic next_source0_sysreg, next_source1_sysreg, next_source1_imm;
	dispatch_pkg::word_t next_sysreg_psr, next_sysreg_tidr, next_spr;
	dispatch_pkg::word_t next_source0, next_source1, next_pc;
	dispatch_pkg::reg_addr_t next_destination, next_source0_ptr, next_source1_ptr;
	logic wb_valid, wb_destination_sysreg, wb_writeback, wb_spr_writeback, wb_branch;
	dispatch_pkg::reg_addr_t wb_destination;
	dispatch_pkg::word_t wb_data, wb_spr, wb_pc, wb_branch_pc;
	int error_count;
	int check_count;
	integer seed;
	dispatch_pkg::word_t pc_next;

	dispatch #(.CORE_ID(CORE_ID)) i_dispatch (.*);
	dispatch_checker #(.CORE_ID(CORE_ID)) i_checker (.*);

	bind dispatch dispatch_asserts i_dispatch_asserts (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .free_refresh(free_refresh),
		.prev_lock(prev_lock), .next_lock(next_lock), .next_valid(next_valid)
	);

	always #5 iCLOCK = ~iCLOCK;

	function automatic dispatch_pkg::word_t rand_word();
		return $random(seed);
	endfunction

	// Wait for an edge, then drop all one-cycle strobes
	task automatic next_cycle();
		@(posedge iCLOCK);
		prev_valid <= 1'b0;
		wb_valid <= 1'b0;
		wb_writeback <= 1'b0;
		wb_spr_writeback <= 1'b0;
		free_refresh <= 1'b0;
		free_set_irq_mode <= 1'b0;
		free_clr_irq_mode <= 1'b0;
		free_ppcr_set <= 1'b0;
	endtask

	task automatic writeback(input logic sys, input dispatch_pkg::reg_addr_t dst,
		input dispatch_pkg::word_t data);
		dispatch_pkg::word_t r;
		r = rand_word();
		wb_valid <= 1'b1;
		wb_writeback <= 1'b1;
		wb_destination_sysreg <= sys;
		wb_destination <= dst;
		wb_data <= data;
		wb_spr <= rand_word();
		wb_branch <= r[0];
		wb_branch_pc <= r;
		wb_pc <= pc_next;
		pc_next = pc_next + 32'd4;
	endtask

	task automatic issue(input dispatch_pkg::reg_addr_t src0, input logic sys0,
		input dispatch_pkg::word_t src1, input logic sys1, input logic imm);
		dispatch_pkg::word_t r;
		r = rand_word();
		prev_valid <= 1'b1;
		prev_source0 <= src0;
		prev_source0_sysreg <= sys0;
		prev_source1 <= src1;
		prev_source1_sysreg <= sys1;
		prev_source1_imm <= imm;
		prev_pc <= r;
		prev_cmd <= r[4:0];
		prev_cc <= r[8:5];
		prev_destination <= r[13:9];
		prev_destination_sysreg <= r[14];
		prev_writeback <= r[15];
	endtask

	task automatic finish_test(input string name, input int start);
		repeat (3) next_cycle();
		$display("%s: %0d errors", name, error_count - start);
	endtask

	initial begin : stimulus
		dispatch_pkg::word_t r;
		int start;
		int failures;
		seed = 32'he12d_cf80;
		pc_next = 32'h0000_1000;
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		{free_pipeline_stop, free_refresh, free_set_irq_mode, free_clr_irq_mode} = '0;
		free_ppcr_set = 1'b0;
		free_ppcr = '0;
		{prev_valid, prev_destination_sysreg, prev_writeback, prev_source0_sysreg} = '0;
		{prev_source1_sysreg, prev_source1_imm, next_lock} = '0;
		{prev_destination, prev_source0, prev_cmd, prev_cc} = '0;
		{prev_source1, prev_pc} = '0;
		{wb_valid, wb_destination_sysreg, wb_writeback, wb_spr_writeback, wb_branch} = '0;
		{wb_destination, wb_data, wb_spr, wb_pc, wb_branch_pc} = '0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		inRESET <= 1'b1;
		repeat (2) next_cycle();

		start = error_count;
		for (int i = 0; i < 48; i++) begin
			next_cycle();
			r = rand_word();
			writeback(1'b0, r[4:0], rand_word());
		end
		next_cycle();
		writeback(1'b0, 5'd0, rand_word());
		for (int i = 0; i < 32; i++) begin
			next_cycle();
			issue(5'(i), 1'b0, 32'(31 - i), 1'b0, 1'b0);
		end
		finish_test("general registers", start);

		start = error_count;
		for (int i = 0; i < 16; i++) begin
			next_cycle();
			r = rand_word();
			writeback(1'b0, r[4:0], rand_word());
			issue(r[4:0], 1'b0, 32'(r[4:0]), 1'b0, 1'b0);
		end
		next_cycle();
		writeback(1'b1, `SYSREG_TIDR, rand_word());
		issue(`SYSREG_PCR, 1'b1, 32'(`SYSREG_TIDR), 1'b1, 1'b0);
		next_cycle();
		writeback(1'b1, `SYSREG_PSR, rand_word());
		wb_spr_writeback <= 1'b1;
		issue(`SYSREG_SPR, 1'b1, 32'(`SYSREG_PSR), 1'b1, 1'b0);
		finish_test("forwarding", start);

		start = error_count;
		next_cycle();
		issue(`SYSREG_CPUIDR, 1'b1, 32'(`SYSREG_COREIDR), 1'b1, 1'b0);
		next_cycle();
		issue(`SYSREG_PCR, 1'b1, 32'(`SYSREG_SPR), 1'b1, 1'b0);
		// Number 3 is no system register and falls back to the general file
		next_cycle();
		issue(5'd3, 1'b1, rand_word(), 1'b1, 1'b1);
		next_cycle();
		writeback(1'b0, 5'd4, rand_word());
		issue(`SYSREG_TIDR, 1'b1, 32'hffff_ff04, 1'b0, 1'b1);
		finish_test("system reads", start);

		start = error_count;
		next_cycle();
		writeback(1'b1, `SYSREG_PSR, 32'hffff_ffff);
		next_cycle();
		writeback(1'b1, `SYSREG_TIDR, rand_word());
		next_cycle();
		free_set_irq_mode <= 1'b1;
		next_cycle();
		issue(`SYSREG_PSR, 1'b1, 32'(`SYSREG_PPSR), 1'b1, 1'b0);
		next_cycle();
		issue(`SYSREG_PTIDR, 1'b1, 32'(`SYSREG_TIDR), 1'b1, 1'b0);
		next_cycle();
		free_clr_irq_mode <= 1'b1;
		next_cycle();
		issue(`SYSREG_PSR, 1'b1, 32'(`SYSREG_PPSR), 1'b1, 1'b0);
		next_cycle();
		free_ppcr_set <= 1'b1;
		free_ppcr <= rand_word();
		next_cycle();
		issue(`SYSREG_PPCR, 1'b1, 32'(`SYSREG_PCR), 1'b1, 1'b0);
		finish_test("interrupt mode", start);

		start = error_count;
		next_cycle();
		issue(5'd7, 1'b0, 32'd9, 1'b0, 1'b0);
		next_cycle();
		next_lock <= 1'b1;
		issue(5'd11, 1'b0, 32'd12, 1'b0, 1'b0);
		for (int i = 0; i < 4; i++) begin
			next_cycle();
			r = rand_word();
			issue(r[4:0], 1'b0, rand_word(), 1'b0, 1'b0);
		end
		next_cycle();
		next_lock <= 1'b0;
		issue(5'd13, 1'b0, 32'd14, 1'b0, 1'b0);
		next_cycle();
		issue(5'd15, 1'b0, 32'd16, 1'b0, 1'b0);
		free_refresh <= 1'b1;
		finish_test("lock and refresh", start);

		start = error_count;
		next_cycle();
		free_pipeline_stop <= 1'b1;
		r = rand_word();
		writeback(1'b0, r[4:0], rand_word());
		issue(r[4:0], 1'b0, 32'(r[4:0]), 1'b0, 1'b0);
		next_cycle();
		writeback(1'b1, `SYSREG_TIDR, rand_word());
		wb_spr_writeback <= 1'b1;
		issue(`SYSREG_TIDR, 1'b1, 32'(`SYSREG_SPR), 1'b1, 1'b0);
		next_cycle();
		free_pipeline_stop <= 1'b0;
		issue(r[4:0], 1'b0, 32'(`SYSREG_TIDR), 1'b1, 1'b0);
		next_cycle();
		issue(`SYSREG_SPR, 1'b1, 32'(r[4:0]), 1'b0, 1'b0);
		finish_test("pipeline stop", start);

		failures = error_count + i_dispatch.i_dispatch_asserts.failures;
		$display("%0d checks, %0d errors, %0d assertion failures", check_count, error_count,
			i_dispatch.i_dispatch_asserts.failures);
		if (failures == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("Timeout at %0t, the tests did not finish in time", $time);
		$display("test failed");
		$finish;
	end

endmodule
